//--- hdl/jesd_tx_pkg.sv
// Shared widths, control characters, link phase codes and configuration
// field types for the JESD204B 8b/10b transmit link layer.
// Modules pull these in with a wildcard import in their header.

package jesd_tx_pkg;

  // **************************************************
  // Data path geometry
  // **************************************************

  localparam int OCTETS_PER_BEAT = 4;
  localparam int BEAT_BITS = OCTETS_PER_BEAT * 8;
  localparam int BEAT_SHIFT = $clog2(OCTETS_PER_BEAT);

  typedef logic [7:0] octet_t;
  typedef octet_t [OCTETS_PER_BEAT-1:0] beat_t;
  typedef logic [OCTETS_PER_BEAT-1:0] charisk_t;

  // Configuration fields, plain counts
  typedef logic [9:0] mf_octets_t;
  typedef logic [7:0] frame_octets_t;
  typedef logic [7:0] beat_cnt_t;

  // **************************************************
  // Link phases, also reported on the status port
  // **************************************************

  typedef enum logic [1:0] {
    PHASE_CGS  = 2'd1,
    PHASE_ILAS = 2'd2,
    PHASE_DATA = 2'd3
  } link_phase_t;

  // **************************************************
  // 8b/10b control characters
  // **************************************************

  // K28.5 comma for code group sync
  localparam octet_t K_CGS = 8'hBC;
  // K28.0 start of ILAS multiframe
  localparam octet_t K_R = 8'h1C;
  // K28.3 end of multiframe
  localparam octet_t K_A = 8'h7C;
  // K28.4 marks the configuration multiframe
  localparam octet_t K_Q = 8'h9C;

endpackage

//--- hdl/jesd_lane_ctrl_if.sv
// Per-beat lane control shared by all lanes of the link.
// The link controller drives it, every lane reads it. All signals are
// levels valid in every cycle, there is no handshake.

`timescale 1ns/1ps

interface jesd_lane_ctrl_if
  import jesd_tx_pkg::*;
();

  link_phase_t phase;
  beat_t       ilas_data;
  charisk_t    ilas_charisk;
  // High in every DATA phase beat
  logic        data_en;
  // First beat of a DATA phase
  logic        sof_start;

  modport ctrl_mp (
    output phase,
    output ilas_data,
    output ilas_charisk,
    output data_en,
    output sof_start
  );

  modport lane_mp (
    input phase,
    input ilas_data,
    input ilas_charisk,
    input data_en,
    input sof_start
  );

endinterface

//--- hdl/jesd_lmfc.sv
// Local multiframe counter for the transmit link.
// Counts beats within a multiframe and pulses o_lmfc_edge on beat 0.
// A SYSREF rising edge realigns the counter; once aligned, a SYSREF that
// lands off the multiframe boundary raises a one-cycle error event.

`timescale 1ns/1ps

module jesd_lmfc
  import jesd_tx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       i_sysref,
  input  mf_octets_t i_cfg_octets_per_multiframe,
  output logic       o_lmfc_edge,
  output logic       o_sysref_alignment_error
);

  beat_cnt_t beats_per_mf;
  beat_cnt_t lmfc_cnt;
  beat_cnt_t lmfc_cnt_free;
  logic      sysref_q;
  logic      sysref_qq;
  logic      sysref_edge;
  logic      aligned;
  logic      align_error;

  assign beats_per_mf = beat_cnt_t'(i_cfg_octets_per_multiframe >> BEAT_SHIFT);

  // Next count when no SYSREF intervenes
  assign lmfc_cnt_free = (lmfc_cnt >= beats_per_mf - 8'd1) ? '0 : lmfc_cnt + 8'd1;

  assign sysref_edge = sysref_q & ~sysref_qq;

  always_ff @(posedge clk) begin
    if (reset) begin
      sysref_q    <= 1'b0;
      sysref_qq   <= 1'b0;
      // Start just past the boundary so no edge shows straight out of reset
      lmfc_cnt    <= 8'd1;
      aligned     <= 1'b0;
      align_error <= 1'b0;
    end else begin
      sysref_q    <= i_sysref;
      sysref_qq   <= sysref_q;
      align_error <= sysref_edge & aligned & (lmfc_cnt_free != '0);
      if (sysref_edge) begin
        lmfc_cnt <= '0;
        aligned  <= 1'b1;
      end else begin
        lmfc_cnt <= lmfc_cnt_free;
      end
    end
  end

  assign o_lmfc_edge = (lmfc_cnt == '0);
  assign o_sysref_alignment_error = align_error;

endmodule

//--- hdl/jesd_frame_mark.sv
// Frame and multiframe boundary flags for the transport layer.
// One flag bit per octet of the current beat, octet 0 in bit 0.
// Counting restarts at octet 0 when i_frame_reset drops.

`timescale 1ns/1ps

module jesd_frame_mark
  import jesd_tx_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          i_frame_reset,
  input  frame_octets_t i_cfg_octets_per_frame,
  input  mf_octets_t    i_cfg_octets_per_multiframe,
  output charisk_t      o_sof,
  output charisk_t      o_eof,
  output charisk_t      o_somf,
  output charisk_t      o_eomf
);

  frame_octets_t frame_pos;
  frame_octets_t frame_next;
  mf_octets_t    mf_pos;
  mf_octets_t    mf_next;
  charisk_t      sof;
  charisk_t      eof;
  charisk_t      somf;
  charisk_t      eomf;

  // Walk the four octets of the beat, frames may be shorter than a beat
  always_comb begin
    frame_octets_t fp;
    mf_octets_t    mp;
    fp = frame_pos;
    mp = mf_pos;
    for (int i = 0; i < OCTETS_PER_BEAT; i++) begin
      sof[i]  = (fp == '0);
      eof[i]  = (fp == i_cfg_octets_per_frame - 8'd1);
      somf[i] = (mp == '0);
      eomf[i] = (mp == i_cfg_octets_per_multiframe - 10'd1);
      fp = eof[i] ? '0 : fp + 8'd1;
      mp = eomf[i] ? '0 : mp + 10'd1;
    end
    frame_next = fp;
    mf_next    = mp;
  end

  always_ff @(posedge clk) begin
    if (reset || i_frame_reset) begin
      frame_pos <= '0;
      mf_pos    <= '0;
    end else begin
      frame_pos <= frame_next;
      mf_pos    <= mf_next;
    end
  end

  assign o_sof  = i_frame_reset ? '0 : sof;
  assign o_eof  = i_frame_reset ? '0 : eof;
  assign o_somf = i_frame_reset ? '0 : somf;
  assign o_eomf = i_frame_reset ? '0 : eomf;

endmodule

//--- hdl/jesd_tx_ctrl.sv
// Link controller for the transmit side.
// Steps CGS -> ILAS -> DATA on LMFC edges while the receiver holds sync
// high, and falls back to CGS when sync drops. Also builds the ILAS beat
// shared by all lanes and the tx_ready / frame reset levels.

`timescale 1ns/1ps

module jesd_tx_ctrl
  import jesd_tx_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_sync,
  input  logic                   i_lmfc_edge,
  input  logic                   i_cfg_continuous_cgs,
  input  logic                   i_cfg_skip_ilas,
  input  octet_t                 i_cfg_mframes_per_ilas,
  input  mf_octets_t             i_cfg_octets_per_multiframe,
  jesd_lane_ctrl_if.ctrl_mp      lane_ctrl,
  output logic                   o_frame_reset,
  output logic                   o_tx_ready,
  output link_phase_t            o_status_state
);

  if (NUM_LANES < 1) begin : gen_lane_check
    $error("NUM_LANES must be at least 1");
  end

  link_phase_t phase;
  link_phase_t phase_next;
  logic        sof_start;
  logic        data_phase;
  octet_t      mf_cnt;
  mf_octets_t  ilas_pos;
  logic        ilas_last_mf;
  beat_t       ilas_data;
  charisk_t    ilas_charisk;

  // **************************************************
  // Phase machine
  // **************************************************

  assign ilas_last_mf = ({1'b0, mf_cnt} + 9'd1) >= {1'b0, i_cfg_mframes_per_ilas};

  always_comb begin
    phase_next = phase;
    case (phase)
      PHASE_CGS: begin
        if (i_sync && !i_cfg_continuous_cgs && i_lmfc_edge) begin
          phase_next = i_cfg_skip_ilas ? PHASE_DATA : PHASE_ILAS;
        end
      end
      PHASE_ILAS: begin
        if (!i_sync) begin
          phase_next = PHASE_CGS;
        end else if (i_lmfc_edge && ilas_last_mf) begin
          phase_next = PHASE_DATA;
        end
      end
      PHASE_DATA: begin
        if (!i_sync) begin
          phase_next = PHASE_CGS;
        end
      end
      default: phase_next = PHASE_CGS;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase     <= PHASE_CGS;
      sof_start <= 1'b0;
      mf_cnt    <= '0;
      ilas_pos  <= '0;
    end else begin
      phase     <= phase_next;
      sof_start <= (phase_next == PHASE_DATA) && (phase != PHASE_DATA);
      if (phase != PHASE_ILAS) begin
        mf_cnt   <= '0;
        ilas_pos <= '0;
      end else if (i_lmfc_edge) begin
        // Edge beat closes the current ILAS multiframe
        mf_cnt   <= mf_cnt + 8'd1;
        ilas_pos <= '0;
      end else begin
        ilas_pos <= ilas_pos + mf_octets_t'(OCTETS_PER_BEAT);
      end
    end
  end

  // **************************************************
  // ILAS pattern, ramp with K_R / K_A / K_Q markers
  // **************************************************

  always_comb begin
    mf_octets_t pos;
    for (int i = 0; i < OCTETS_PER_BEAT; i++) begin
      pos = ilas_pos + mf_octets_t'(i);
      if (pos == '0) begin
        ilas_data[i]    = K_R;
        ilas_charisk[i] = 1'b1;
      end else if (pos == i_cfg_octets_per_multiframe - 10'd1) begin
        ilas_data[i]    = K_A;
        ilas_charisk[i] = 1'b1;
      end else if (mf_cnt == 8'd1 && pos == 10'd1) begin
        ilas_data[i]    = K_Q;
        ilas_charisk[i] = 1'b1;
      end else begin
        ilas_data[i]    = pos[7:0];
        ilas_charisk[i] = 1'b0;
      end
    end
  end

  assign data_phase = (phase == PHASE_DATA);

  assign lane_ctrl.phase        = phase;
  assign lane_ctrl.ilas_data    = ilas_data;
  assign lane_ctrl.ilas_charisk = ilas_charisk;
  assign lane_ctrl.data_en      = data_phase;
  assign lane_ctrl.sof_start    = sof_start;

  assign o_tx_ready     = data_phase;
  assign o_frame_reset  = ~data_phase;
  assign o_status_state = phase;

endmodule

//--- hdl/jesd_tx_lane.sv
// One transmit lane.
// Picks the K28.5 comma, the ILAS beat or user data by link phase and
// registers it to the PHY. User data goes through the self-synchronizing
// scrambler 1 + x^14 + x^15 unless it is bypassed. Disabled lanes send zeros.

`timescale 1ns/1ps

module jesd_tx_lane
  import jesd_tx_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  jesd_lane_ctrl_if.lane_mp lane_ctrl,
  input  beat_t             i_tx_data,
  input  logic              i_lane_disable,
  input  logic              i_cfg_disable_scrambler,
  output beat_t             o_phy_data,
  output charisk_t          o_phy_charisk
);

  logic [14:0]          scr_state;
  logic [14:0]          scr_seed;
  logic [BEAT_BITS-1:0] scr_in;
  logic [BEAT_BITS-1:0] scr_out;
  beat_t                scr_beat;
  beat_t                data_sel;
  charisk_t             charisk_sel;

  // **************************************************
  // Scrambler
  // **************************************************

  // Serial order is octet 0 first, MSB first
  assign scr_in = {i_tx_data[0], i_tx_data[1], i_tx_data[2], i_tx_data[3]};

  // Fresh start on the first DATA beat
  assign scr_seed = lane_ctrl.sof_start ? '0 : scr_state;

  always_comb begin
    logic [BEAT_BITS+14:0] ext;
    ext = {scr_seed, {BEAT_BITS{1'b0}}};
    for (int j = BEAT_BITS - 1; j >= 0; j--) begin
      ext[j] = scr_in[j] ^ ext[j+14] ^ ext[j+15];
    end
    scr_out = ext[BEAT_BITS-1:0];
  end

  assign scr_beat = {scr_out[7:0], scr_out[15:8], scr_out[23:16], scr_out[31:24]};

  always_ff @(posedge clk) begin
    if (lane_ctrl.data_en) begin
      scr_state <= scr_out[14:0];
    end
  end

  // **************************************************
  // Character selection and output register
  // **************************************************

  always_comb begin
    data_sel    = '0;
    charisk_sel = '0;
    if (!i_lane_disable) begin
      if (lane_ctrl.data_en) begin
        data_sel = i_cfg_disable_scrambler ? i_tx_data : scr_beat;
      end else if (lane_ctrl.phase == PHASE_ILAS) begin
        data_sel    = lane_ctrl.ilas_data;
        charisk_sel = lane_ctrl.ilas_charisk;
      end else if (lane_ctrl.phase == PHASE_CGS) begin
        data_sel    = {OCTETS_PER_BEAT{K_CGS}};
        charisk_sel = '1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      o_phy_data    <= '0;
      o_phy_charisk <= '0;
    end else begin
      o_phy_data    <= data_sel;
      o_phy_charisk <= charisk_sel;
    end
  end

endmodule

//--- hdl/jesd_tx.sv
// JESD204B 8b/10b transmit link layer, single link, single clock.
// Connects the LMFC, frame marker and link controller, and drives
// NUM_LANES lanes from one shared lane control bus. Lane n takes
// i_tx_data[n] and drives o_phy_data[n] / o_phy_charisk[n].

`timescale 1ns/1ps

module jesd_tx
  import jesd_tx_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           i_sysref,
  input  logic                           i_sync,
  input  beat_t      [NUM_LANES-1:0]     i_tx_data,
  output logic                           o_tx_ready,
  output charisk_t                       o_tx_sof,
  output charisk_t                       o_tx_eof,
  output charisk_t                       o_tx_somf,
  output charisk_t                       o_tx_eomf,
  output beat_t      [NUM_LANES-1:0]     o_phy_data,
  output charisk_t   [NUM_LANES-1:0]     o_phy_charisk,
  output logic                           o_lmfc_edge,
  output logic                           o_sysref_alignment_error,
  output link_phase_t                    o_status_state,
  input  logic       [NUM_LANES-1:0]     i_cfg_lanes_disable,
  input  frame_octets_t                  i_cfg_octets_per_frame,
  input  mf_octets_t                     i_cfg_octets_per_multiframe,
  input  logic                           i_cfg_continuous_cgs,
  input  logic                           i_cfg_skip_ilas,
  input  octet_t                         i_cfg_mframes_per_ilas,
  input  logic                           i_cfg_disable_scrambler
);

  logic lmfc_edge;
  logic frame_reset;

  jesd_lane_ctrl_if lane_ctrl ();

  jesd_lmfc lmfc_i (
    .clk                         (clk),
    .reset                       (reset),
    .i_sysref                    (i_sysref),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .o_lmfc_edge                 (lmfc_edge),
    .o_sysref_alignment_error    (o_sysref_alignment_error)
  );

  jesd_frame_mark frame_mark_i (
    .clk                         (clk),
    .reset                       (reset),
    .i_frame_reset               (frame_reset),
    .i_cfg_octets_per_frame      (i_cfg_octets_per_frame),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .o_sof                       (o_tx_sof),
    .o_eof                       (o_tx_eof),
    .o_somf                      (o_tx_somf),
    .o_eomf                      (o_tx_eomf)
  );

  jesd_tx_ctrl #(
    .NUM_LANES (NUM_LANES)
  ) ctrl_i (
    .clk                         (clk),
    .reset                       (reset),
    .i_sync                      (i_sync),
    .i_lmfc_edge                 (lmfc_edge),
    .i_cfg_continuous_cgs        (i_cfg_continuous_cgs),
    .i_cfg_skip_ilas             (i_cfg_skip_ilas),
    .i_cfg_mframes_per_ilas      (i_cfg_mframes_per_ilas),
    .i_cfg_octets_per_multiframe (i_cfg_octets_per_multiframe),
    .lane_ctrl                   (lane_ctrl),
    .o_frame_reset               (frame_reset),
    .o_tx_ready                  (o_tx_ready),
    .o_status_state              (o_status_state)
  );

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    jesd_tx_lane lane_i (
      .clk                     (clk),
      .reset                   (reset),
      .lane_ctrl               (lane_ctrl),
      .i_tx_data               (i_tx_data[l]),
      .i_lane_disable          (i_cfg_lanes_disable[l]),
      .i_cfg_disable_scrambler (i_cfg_disable_scrambler),
      .o_phy_data              (o_phy_data[l]),
      .o_phy_charisk           (o_phy_charisk[l])
    );
  end

  assign o_lmfc_edge = lmfc_edge;

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock and power-on reset.
// Makes a 4 ns clock and holds reset high for the first 3 rising edges.

`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (3) @(posedge o_clk);
    #1 o_reset = 1'b0;
  end

endmodule

//--- dv/jesd_tx_checker.sv
// Watches the ports of the transmit link and checks them against its own
// model of CGS, ILAS, DATA, frame flags and LMFC behavior.
// Errors are counted here; the testbench top reads the counts at the end.

`timescale 1ns/1ps

module jesd_tx_checker
  import jesd_tx_pkg::*;
#(
  parameter int NUM_LANES = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       i_sysref,
  input  beat_t    [NUM_LANES-1:0]   i_tx_data,
  input  logic                       o_tx_ready,
  input  charisk_t                   o_tx_sof,
  input  charisk_t                   o_tx_eof,
  input  charisk_t                   o_tx_somf,
  input  charisk_t                   o_tx_eomf,
  input  beat_t    [NUM_LANES-1:0]   o_phy_data,
  input  charisk_t [NUM_LANES-1:0]   o_phy_charisk,
  input  logic                       o_lmfc_edge,
  input  logic                       o_sysref_alignment_error,
  input  link_phase_t                o_status_state,
  input  logic     [NUM_LANES-1:0]   i_cfg_lanes_disable,
  input  frame_octets_t              i_cfg_octets_per_frame,
  input  mf_octets_t                 i_cfg_octets_per_multiframe,
  input  logic                       i_cfg_skip_ilas,
  input  octet_t                     i_cfg_mframes_per_ilas,
  input  logic                       i_cfg_disable_scrambler
);

  int mismatch_cnt = 0;
  int fail_cnt = 0;
  int align_err_cnt = 0;

  // State seen on the previous edge, which drove the current lane outputs
  bit                     rst_q = 1'b1;
  link_phase_t            phase_q;
  beat_t [NUM_LANES-1:0]  data_q;
  logic [NUM_LANES-1:0]   dis_q;
  logic                   noscr_q;

  bit   ilas_active;
  int   ilas_pos;
  int   ilas_mf;
  int   octet_n;
  int   data_beats;
  int   edge_gap;
  bit   edge_seen;
  logic [3:0]  sref_hist;
  logic [14:0] hist [NUM_LANES];

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
    mismatch_cnt++;
  endtask

  task automatic failure(input string what);
    $display("ERROR t=%0t %s", $time, what);
    fail_cnt++;
  endtask

  // {charisk, octet} of one ILAS octet
  function automatic logic [8:0] ilas_octet(input int pos, input int mf, input int mfo);
    if (pos == 0) return {1'b1, K_R};
    if (pos == mfo - 1) return {1'b1, K_A};
    if (mf == 1 && pos == 1) return {1'b1, K_Q};
    return {1'b0, octet_t'(pos)};
  endfunction

  task automatic check_align(input int exp);
    if (align_err_cnt != exp) begin
      mismatch("o_sysref_alignment_error pulses", 32'(exp), 32'(align_err_cnt));
    end
  endtask

  always @(posedge clk) begin : watch
    beat_t        exp_beat;
    charisk_t     exp_k;
    bit           chk_data;
    logic [8:0]   ko;
    logic [31:0]  bits;
    logic [31:0]  dbits;
    logic [31:0]  ref_bits;
    logic [14:0]  h;
    logic         s;
    charisk_t     e_sof;
    charisk_t     e_eof;
    charisk_t     e_somf;
    charisk_t     e_eomf;
    int           n;
    int           fpo;
    int           mfo;
    fpo = int'(i_cfg_octets_per_frame);
    mfo = int'(i_cfg_octets_per_multiframe);
    if (reset) begin
      rst_q         = 1'b1;
      ilas_active   = 1'b0;
      octet_n       = 0;
      data_beats    = 0;
      edge_seen     = 1'b0;
      align_err_cnt = 0;
      sref_hist     = '0;
    end else begin
      if (!rst_q) begin
        if (phase_q == PHASE_ILAS && !ilas_active) begin
          ilas_active = 1'b1;
          ilas_pos    = 0;
          ilas_mf     = 0;
          if (i_cfg_skip_ilas) failure("ILAS beat sent while skip_ilas is set");
        end
        for (int l = 0; l < NUM_LANES; l++) begin
          exp_beat = '0;
          exp_k    = '0;
          chk_data = 1'b1;
          if (!dis_q[l]) begin
            case (phase_q)
              PHASE_CGS: begin
                exp_beat = {OCTETS_PER_BEAT{K_CGS}};
                exp_k    = '1;
              end
              PHASE_ILAS: begin
                for (int i = 0; i < OCTETS_PER_BEAT; i++) begin
                  ko          = ilas_octet(ilas_pos + i, ilas_mf, mfo);
                  exp_beat[i] = ko[7:0];
                  exp_k[i]    = ko[8];
                end
              end
              default: begin
                bits = {o_phy_data[l][0], o_phy_data[l][1], o_phy_data[l][2], o_phy_data[l][3]};
                h = hist[l];
                for (int j = 31; j >= 0; j--) begin
                  s        = bits[j];
                  dbits[j] = s ^ h[13] ^ h[14];
                  h        = {h[13:0], s};
                end
                hist[l] = h;
                ref_bits = {data_q[l][0], data_q[l][1], data_q[l][2], data_q[l][3]};
                if (noscr_q) begin
                  exp_beat = data_q[l];
                end else begin
                  // Scrambled data is checked through the descrambler
                  chk_data = 1'b0;
                  // Descrambler needs one beat of history
                  if (data_beats > 0 && dbits != ref_bits) begin
                    mismatch($sformatf("lane%0d descrambled data", l), ref_bits, dbits);
                  end
                end
              end
            endcase
          end
          if (chk_data && o_phy_data[l] != exp_beat) begin
            mismatch($sformatf("lane%0d o_phy_data", l), exp_beat, o_phy_data[l]);
          end
          if (o_phy_charisk[l] != exp_k) begin
            mismatch($sformatf("lane%0d o_phy_charisk", l), 32'(exp_k), 32'(o_phy_charisk[l]));
          end
        end
        // ILAS position model
        if (phase_q == PHASE_ILAS) begin
          ilas_pos += OCTETS_PER_BEAT;
          if (ilas_pos >= mfo) begin
            ilas_pos = 0;
            ilas_mf++;
          end
        end else if (ilas_active) begin
          ilas_active = 1'b0;
          if (ilas_mf != int'(i_cfg_mframes_per_ilas)) begin
            mismatch("ILAS multiframe count", 32'(i_cfg_mframes_per_ilas), 32'(ilas_mf));
          end
        end
        data_beats = (phase_q == PHASE_DATA) ? data_beats + 1 : 0;
      end

      // **************************************************
      // Frame flags in the same cycle as the beat
      // **************************************************
      e_sof  = '0;
      e_eof  = '0;
      e_somf = '0;
      e_eomf = '0;
      if (o_tx_ready) begin
        for (int i = 0; i < OCTETS_PER_BEAT; i++) begin
          n         = octet_n + i;
          e_sof[i]  = (n % fpo == 0);
          e_eof[i]  = (n % fpo == fpo - 1);
          e_somf[i] = (n % mfo == 0);
          e_eomf[i] = (n % mfo == mfo - 1);
        end
        octet_n += OCTETS_PER_BEAT;
      end else begin
        octet_n = 0;
      end
      if (o_tx_sof != e_sof) mismatch("o_tx_sof", 32'(e_sof), 32'(o_tx_sof));
      if (o_tx_eof != e_eof) mismatch("o_tx_eof", 32'(e_eof), 32'(o_tx_eof));
      if (o_tx_somf != e_somf) mismatch("o_tx_somf", 32'(e_somf), 32'(o_tx_somf));
      if (o_tx_eomf != e_eomf) mismatch("o_tx_eomf", 32'(e_eomf), 32'(o_tx_eomf));

      // LMFC period is not checked across a SYSREF realignment
      sref_hist = {sref_hist[2:0], i_sysref};
      if (|sref_hist) edge_seen = 1'b0;
      if (o_lmfc_edge) begin
        if (edge_seen && edge_gap != mfo / OCTETS_PER_BEAT) begin
          mismatch("o_lmfc_edge period", 32'(mfo / OCTETS_PER_BEAT), 32'(edge_gap));
        end
        edge_seen = 1'b1;
        edge_gap  = 1;
      end else begin
        edge_gap++;
      end
      if (o_sysref_alignment_error) align_err_cnt++;
      rst_q = 1'b0;
    end
    phase_q = o_status_state;
    data_q  = i_tx_data;
    dis_q   = i_cfg_lanes_disable;
    noscr_q = i_cfg_disable_scrambler;
  end

endmodule

//--- dv/jesd_tx_sva.sv
// Concurrent checks on the link controller phase machine.
// Bound into every jesd_tx_ctrl instance.

`timescale 1ns/1ps

module jesd_tx_sva
  import jesd_tx_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input link_phase_t phase,
  input logic        tx_ready,
  input logic        skip_ilas,
  input logic        lmfc_edge
);

  a_ready_on_edge: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_ready) |-> $past(lmfc_edge))
    else $error("tx_ready rose without an LMFC edge in the cycle before");

  a_no_skip_without_cfg: assert property (@(posedge clk) disable iff (reset)
    (phase == PHASE_CGS && !skip_ilas) |=> (phase != PHASE_DATA))
    else $error("CGS went straight to DATA without skip_ilas");

  a_leave_cgs_on_edge: assert property (@(posedge clk) disable iff (reset)
    (phase == PHASE_CGS && !lmfc_edge) |=> (phase == PHASE_CGS))
    else $error("CGS left without an LMFC edge");

endmodule

bind jesd_tx_ctrl jesd_tx_sva sva_i (
  .clk       (clk),
  .reset     (reset),
  .phase     (phase),
  .tx_ready  (o_tx_ready),
  .skip_ilas (i_cfg_skip_ilas),
  .lmfc_edge (i_lmfc_edge)
);

//--- dv/tb_jesd_tx.sv
// Testbench top for the JESD204B transmit link layer.
// Runs each configuration row through reset, SYSREF, sync release, DATA
// with random beats, an optional late SYSREF and loss of sync back to CGS.

`timescale 1ns/1ps

module tb_jesd_tx
  import jesd_tx_pkg::*;
();

  localparam int NUM_LANES = 2;
  localparam int WAIT_LIMIT = 2000;

  typedef struct {
    int         fpo;
    int         mfo;
    int         mframes;
    bit         skip;
    bit         noscr;
    logic [1:0] dis;
    int         sync_at;
    bit         late;
  } row_t;

  logic clk;
  logic gen_reset;
  logic row_reset;
  logic reset;
  logic sysref;
  logic sync;
  beat_t         [NUM_LANES-1:0] tx_data;
  logic          [NUM_LANES-1:0] lanes_disable;
  frame_octets_t cfg_fpo;
  mf_octets_t    cfg_mfo;
  octet_t        cfg_mframes;
  logic          cfg_skip;
  logic          cfg_noscr;

  logic          tx_ready;
  charisk_t      tx_sof;
  charisk_t      tx_eof;
  charisk_t      tx_somf;
  charisk_t      tx_eomf;
  beat_t         [NUM_LANES-1:0] phy_data;
  charisk_t      [NUM_LANES-1:0] phy_charisk;
  logic          lmfc_edge;
  logic          align_err;
  link_phase_t   state;

  row_t rows [4];
  int   seed;
  int   timeout_cnt;

  assign reset = gen_reset | row_reset;

  tb_clk_gen clk_gen_i (.o_clk(clk), .o_reset(gen_reset));

  jesd_tx #(.NUM_LANES(NUM_LANES)) dut_i (
    .clk(clk), .reset(reset), .i_sysref(sysref), .i_sync(sync), .i_tx_data(tx_data),
    .o_tx_ready(tx_ready), .o_tx_sof(tx_sof), .o_tx_eof(tx_eof), .o_tx_somf(tx_somf),
    .o_tx_eomf(tx_eomf), .o_phy_data(phy_data), .o_phy_charisk(phy_charisk),
    .o_lmfc_edge(lmfc_edge), .o_sysref_alignment_error(align_err), .o_status_state(state),
    .i_cfg_lanes_disable(lanes_disable), .i_cfg_octets_per_frame(cfg_fpo),
    .i_cfg_octets_per_multiframe(cfg_mfo), .i_cfg_continuous_cgs(1'b0),
    .i_cfg_skip_ilas(cfg_skip), .i_cfg_mframes_per_ilas(cfg_mframes),
    .i_cfg_disable_scrambler(cfg_noscr)
  );

  jesd_tx_checker #(.NUM_LANES(NUM_LANES)) checker_i (
    .clk(clk), .reset(reset), .i_sysref(sysref), .i_tx_data(tx_data),
    .o_tx_ready(tx_ready), .o_tx_sof(tx_sof), .o_tx_eof(tx_eof), .o_tx_somf(tx_somf),
    .o_tx_eomf(tx_eomf), .o_phy_data(phy_data), .o_phy_charisk(phy_charisk),
    .o_lmfc_edge(lmfc_edge), .o_sysref_alignment_error(align_err), .o_status_state(state),
    .i_cfg_lanes_disable(lanes_disable), .i_cfg_octets_per_frame(cfg_fpo),
    .i_cfg_octets_per_multiframe(cfg_mfo), .i_cfg_skip_ilas(cfg_skip),
    .i_cfg_mframes_per_ilas(cfg_mframes), .i_cfg_disable_scrambler(cfg_noscr)
  );

  // New random beat on every lane each cycle
  always @(posedge clk) begin
    #1;
    for (int l = 0; l < NUM_LANES; l++) begin
      tx_data[l] = beat_t'($random(seed));
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!tx_ready && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (!tx_ready) begin
      $display("ERROR t=%0t tx_ready never rose after sync release", $time);
      timeout_cnt++;
    end
  endtask

  task automatic wait_lmfc();
    int n;
    n = 0;
    while (!lmfc_edge && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (!lmfc_edge) begin
      $display("ERROR t=%0t no LMFC edge seen", $time);
      timeout_cnt++;
    end
  endtask

  task automatic wait_cgs();
    int n;
    n = 0;
    while ((state != PHASE_CGS || tx_ready) && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (state != PHASE_CGS || tx_ready) begin
      $display("ERROR t=%0t link did not return to CGS after sync loss", $time);
      timeout_cnt++;
    end
  endtask

  task automatic run_row(input row_t r);
    step();
    sync          = 1'b0;
    cfg_fpo       = frame_octets_t'(r.fpo);
    cfg_mfo       = mf_octets_t'(r.mfo);
    cfg_mframes   = octet_t'(r.mframes);
    cfg_skip      = r.skip;
    cfg_noscr     = r.noscr;
    lanes_disable = r.dis;
    row_reset     = 1'b1;
    repeat (3) step();
    row_reset = 1'b0;
    repeat (2) step();
    sysref = 1'b1;
    step();
    sysref = 1'b0;
    repeat (r.sync_at) step();
    sync = 1'b1;
    wait_ready();
    if (r.late) begin
      // One beat past the boundary
      wait_lmfc();
      sysref = 1'b1;
      step();
      sysref = 1'b0;
    end
    repeat (40) step();
    sync = 1'b0;
    wait_cgs();
    repeat (20) step();
    checker_i.check_align(r.late ? 1 : 0);
  endtask

  initial begin
    seed          = 32'h9b48_6c8d;
    timeout_cnt   = 0;
    row_reset     = 1'b0;
    sysref        = 1'b0;
    sync          = 1'b0;
    tx_data       = '0;
    lanes_disable = '0;
    cfg_fpo       = 8'd4;
    cfg_mfo       = 10'd32;
    cfg_mframes   = 8'd4;
    cfg_skip      = 1'b0;
    cfg_noscr     = 1'b1;
    rows[0] = '{4, 32, 4, 1'b0, 1'b1, 2'b00, 20, 1'b1};
    rows[1] = '{2, 64, 2, 1'b0, 1'b0, 2'b10, 10, 1'b0};
    rows[2] = '{1, 16, 1, 1'b1, 1'b0, 2'b01, 30, 1'b1};
    rows[3] = '{8, 32, 3, 1'b0, 1'b0, 2'b00, 5, 1'b0};
    for (int i = 0; i < 10 && gen_reset; i++) step();
    if (gen_reset) begin
      $display("ERROR t=%0t power-on reset was never released", $time);
      timeout_cnt++;
    end
    foreach (rows[i]) run_row(rows[i]);
    $display("Summary: mismatches=%0d other_errors=%0d timeouts=%0d",
             checker_i.mismatch_cnt, checker_i.fail_cnt, timeout_cnt);
    if (checker_i.mismatch_cnt + checker_i.fail_cnt + timeout_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #100000;
    $display("ERROR t=%0t simulation watchdog expired", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
hdl/jesd_tx_pkg.sv
hdl/jesd_lane_ctrl_if.sv
hdl/jesd_lmfc.sv
hdl/jesd_frame_mark.sv
hdl/jesd_tx_ctrl.sv
hdl/jesd_tx_lane.sv
hdl/jesd_tx.sv
dv/tb_clk_gen.sv
dv/jesd_tx_checker.sv
dv/jesd_tx_sva.sv
dv/tb_jesd_tx.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_jesd_tx
FILELIST   := verilog.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
